//--- design/game_clock_pkg.sv
package game_clock_pkg;

  // remaining game time, as shown on the board display
  typedef struct packed {
    logic [2:0] min;
    // tens of seconds, 0 to 5
    logic [2:0] sec_ten;
    logic [3:0] sec_one;
  } game_time_t;

  // tick rate band, picked from the remaining time
  typedef enum logic [1:0] {
    PACE_NORMAL,
    PACE_FAST,
    PACE_FASTER
  } tick_pace_e;

  // cycles from one tick start to the next
  // scaled down so a simulation sees several ticks
  localparam logic [8:0] TICK_PERIOD_NORMAL = 9'd400;
  localparam logic [8:0] TICK_PERIOD_FAST   = 9'd200;
  localparam logic [8:0] TICK_PERIOD_FASTER = 9'd100;

  // time bands, in tens of seconds with zero minutes left
  // fast from 0:39, faster from 0:19
  localparam logic [2:0] FAST_SEC_TEN_MAX   = 3'd3;
  localparam logic [2:0] FASTER_SEC_TEN_MAX = 3'd1;

endpackage

//--- design/audio_cue_pkg.sv
package audio_cue_pkg;

  // cue currently driven onto the buzzer
  typedef enum logic [2:0] {
    CUE_NONE,
    CUE_ERR,
    CUE_BOOM,
    CUE_PZL,
    CUE_TICK
  } cue_e;

  // play state of any single cue
  typedef enum logic {
    CUE_IDLE,
    CUE_PLAY
  } cue_state_e;

  // one bit per event cue
  // carries play levels one way and done pulses the other
  typedef struct packed {
    logic err;
    logic boom;
    logic pzl;
  } event_cue_t;

  // tone shapes, half period in cycles and toggle count
  // toggle counts are even so every cue ends low
  // error buzz, short and sharp
  localparam logic [3:0] ERR_HALF     = 4'd6;
  localparam logic [4:0] ERR_TOGGLES  = 5'd20;

  // boom, lowest pitch
  localparam logic [3:0] BOOM_HALF    = 4'd15;
  localparam logic [4:0] BOOM_TOGGLES = 5'd16;

  // puzzle chirp
  localparam logic [3:0] PZL_HALF     = 4'd9;
  localparam logic [4:0] PZL_TOGGLES  = 5'd12;

  // countdown tick, 3 short pulses
  localparam logic [3:0] TICK_HALF    = 4'd4;
  localparam logic [4:0] TICK_TOGGLES = 5'd6;

endpackage

//--- design/tick_pacer.sv
`timescale 1ns/100ps

module tick_pacer (
  input  logic                     clk,
  input  logic                     nrst,
  input  game_clock_pkg::game_time_t game_time,
  input  logic                     tick_done,
  output logic                     tick_act
);

  import game_clock_pkg::*;
  import audio_cue_pkg::*;

  tick_pace_e pace;
  logic [8:0] period;
  logic [8:0] pcnt;
  logic       wrap;
  cue_state_e tick_state;
  cue_state_e nxt_tick_state;

  // pace band from the remaining time
  always_comb begin
    if (game_time.min == 3'd0 && game_time.sec_ten <= FASTER_SEC_TEN_MAX) begin
      pace = PACE_FASTER;
    end else if (game_time.min == 3'd0 && game_time.sec_ten <= FAST_SEC_TEN_MAX) begin
      pace = PACE_FAST;
    end else begin
      pace = PACE_NORMAL;
    end
  end

  always_comb begin
    case (pace)
      PACE_FAST:   period = TICK_PERIOD_FAST;
      PACE_FASTER: period = TICK_PERIOD_FASTER;
      default:     period = TICK_PERIOD_NORMAL;
    endcase
  end

  // >= so a shorter period wraps at once
  assign wrap = (pcnt >= period - 9'd1);

  // free running from reset
  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      pcnt <= '0;
    end else if (wrap) begin
      pcnt <= '0;
    end else begin
      pcnt <= pcnt + 9'd1;
    end
  end

  // a wrap while still playing is dropped
  always_comb begin
    nxt_tick_state = tick_state;
    case (tick_state)
      CUE_IDLE: if (wrap) nxt_tick_state = CUE_PLAY;
      CUE_PLAY: if (tick_done) nxt_tick_state = CUE_IDLE;
      default:  nxt_tick_state = CUE_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      tick_state <= CUE_IDLE;
    end else begin
      tick_state <= nxt_tick_state;
    end
  end

  assign tick_act = (tick_state == CUE_PLAY);

  // synth only ends a tick that is playing
  a_done_while_act: assert property (@(posedge clk) disable iff (!nrst)
    tick_done |-> tick_act);

endmodule

//--- design/event_cue_ctrl.sv
`timescale 1ns/100ps

module event_cue_ctrl (
  input  logic                     clk,
  input  logic                     nrst,
  input  logic                     error,
  input  logic                     game_clear,
  input  logic                     puzzle_clear,
  input  audio_cue_pkg::event_cue_t event_done,
  output audio_cue_pkg::event_cue_t event_act
);

  import audio_cue_pkg::*;

  cue_state_e err_state;
  cue_state_e boom_state;
  cue_state_e pzl_state;
  cue_state_e nxt_err_state;
  cue_state_e nxt_boom_state;
  cue_state_e nxt_pzl_state;

  // shared transition of one event cue
  // trigger only counts from idle, done only from play
  function automatic cue_state_e cue_step(
    input cue_state_e cur,
    input logic       trig,
    input logic       done
  );
    cue_state_e nxt;
    nxt = cur;
    case (cur)
      CUE_IDLE: begin
        if (trig) nxt = CUE_PLAY;
      end
      CUE_PLAY: begin
        // retrigger while playing is ignored
        if (done) nxt = CUE_IDLE;
      end
      default: nxt = CUE_IDLE;
    endcase
    return nxt;
  endfunction

  // error buzz
  always_comb begin
    nxt_err_state = cue_step(err_state, error, event_done.err);
  end

  // boom at end of game
  always_comb begin
    nxt_boom_state = cue_step(boom_state, game_clear, event_done.boom);
  end

  // puzzle cleared chirp
  always_comb begin
    nxt_pzl_state = cue_step(pzl_state, puzzle_clear, event_done.pzl);
  end

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      err_state  <= CUE_IDLE;
      boom_state <= CUE_IDLE;
      pzl_state  <= CUE_IDLE;
    end else begin
      err_state  <= nxt_err_state;
      boom_state <= nxt_boom_state;
      pzl_state  <= nxt_pzl_state;
    end
  end

  // play levels out to the synth
  // a preempted cue keeps its level
  always_comb begin
    event_act.err  = (err_state == CUE_PLAY);
    event_act.boom = (boom_state == CUE_PLAY);
    event_act.pzl  = (pzl_state == CUE_PLAY);
  end

  // synth may only finish a cue that is playing here
  a_done_only_in_play: assert property (@(posedge clk) disable iff (!nrst)
    (event_done & ~event_act) == 3'b000);

endmodule

//--- design/tone_synth.sv
`timescale 1ns/100ps

module tone_synth (
  input  logic                     clk,
  input  logic                     nrst,
  input  audio_cue_pkg::event_cue_t event_act,
  input  logic                     tick_act,
  output audio_cue_pkg::event_cue_t event_done,
  output logic                     tick_done,
  output logic                     audio
);

  import audio_cue_pkg::*;

  cue_e       sel;
  cue_e       cur_cue;
  logic [3:0] half;
  logic [4:0] toggles;
  logic [3:0] hcnt;
  logic [4:0] tcnt;
  logic       restart;
  logic       finished;

  // priority, error over boom over puzzle over tick
  always_comb begin
    if (event_act.err) begin
      sel = CUE_ERR;
    end else if (event_act.boom) begin
      sel = CUE_BOOM;
    end else if (event_act.pzl) begin
      sel = CUE_PZL;
    end else if (tick_act) begin
      sel = CUE_TICK;
    end else begin
      sel = CUE_NONE;
    end
  end

  // tone shape of the selected cue
  always_comb begin
    case (sel)
      CUE_ERR:  begin half = ERR_HALF;  toggles = ERR_TOGGLES;  end
      CUE_BOOM: begin half = BOOM_HALF; toggles = BOOM_TOGGLES; end
      CUE_PZL:  begin half = PZL_HALF;  toggles = PZL_TOGGLES;  end
      CUE_TICK: begin half = TICK_HALF; toggles = TICK_TOGGLES; end
      default:  begin half = '0;        toggles = '0;           end
    endcase
  end

  // new cue or preemption, counters start over
  assign restart  = (sel != cur_cue);
  assign finished = (tcnt == toggles);

  // done pulse held until the play state drops
  always_comb begin
    event_done = '0;
    tick_done  = 1'b0;
    if (!restart && finished) begin
      case (sel)
        CUE_ERR:  event_done.err  = 1'b1;
        CUE_BOOM: event_done.boom = 1'b1;
        CUE_PZL:  event_done.pzl  = 1'b1;
        CUE_TICK: tick_done       = 1'b1;
        default:  tick_done       = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      cur_cue <= CUE_NONE;
      hcnt    <= '0;
      tcnt    <= '0;
      audio   <= 1'b0;
    end else if (restart) begin
      cur_cue <= sel;
      // the restart edge is the first cycle of the first half
      hcnt    <= (sel == CUE_NONE) ? 4'd0 : 4'd1;
      tcnt    <= '0;
      audio   <= 1'b0;
    end else if (sel != CUE_NONE && !finished) begin
      if (hcnt == half - 4'd1) begin
        hcnt  <= '0;
        tcnt  <= tcnt + 5'd1;
        audio <= ~audio;
      end else begin
        hcnt <= hcnt + 4'd1;
      end
    end
  end

  // every cue ends low, so silence is really silent
  a_quiet_when_none: assert property (@(posedge clk) disable iff (!nrst)
    (sel == CUE_NONE) |-> !audio);

  // only the playing cue can finish
  a_one_done: assert property (@(posedge clk) disable iff (!nrst)
    $onehot0({event_done, tick_done}));

endmodule

//--- design/audio_top.sv
`timescale 1ns/100ps

module audio_top (
  input  logic                       clk,
  input  logic                       nrst,
  input  game_clock_pkg::game_time_t game_time,
  input  logic                       error,
  input  logic                       puzzle_clear,
  input  logic                       game_clear,
  output logic                       audio
);

  import audio_cue_pkg::*;

  // play levels and done pulses between the blocks
  event_cue_t event_act;
  event_cue_t event_done;
  logic       tick_act;
  logic       tick_done;

  // countdown tick timing
  tick_pacer u_tick_pacer (
    .clk       (clk),
    .nrst      (nrst),
    .game_time (game_time),
    .tick_done (tick_done),
    .tick_act  (tick_act)
  );

  // error, boom and puzzle play states
  event_cue_ctrl u_event_cue_ctrl (
    .clk          (clk),
    .nrst         (nrst),
    .error        (error),
    .game_clear   (game_clear),
    .puzzle_clear (puzzle_clear),
    .event_done   (event_done),
    .event_act    (event_act)
  );

  tone_synth u_tone_synth (
    .clk        (clk),
    .nrst       (nrst),
    .event_act  (event_act),
    .tick_act   (tick_act),
    .event_done (event_done),
    .tick_done  (tick_done),
    .audio      (audio)
  );

endmodule

//--- verification/audio_tb.sv
`timescale 1ns/100ps

module audio_tb;

  import game_clock_pkg::*;
  import audio_cue_pkg::*;

  localparam int CLK_HALF_NS = 10;
  // all tests take about 3500 cycles
  localparam int WATCHDOG_CYCLES = 8000;
  // longer than the widest half period, so a burst is surely over
  localparam int QUIET_CYCLES = 20;

  logic       clk;
  logic       nrst;
  game_time_t game_time;
  logic       error;
  logic       puzzle_clear;
  logic       game_clear;
  logic       audio;

  // posedge count, used to time burst starts
  int cyc = 0;
  int burst_rise;
  int last_rise;
  int last_gap;

  audio_top u_dut (
    .clk          (clk),
    .nrst         (nrst),
    .game_time    (game_time),
    .error        (error),
    .puzzle_clear (puzzle_clear),
    .game_clear   (game_clear),
    .audio        (audio)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF_NS) clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // ends a run that stopped making progress
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the test did not finish", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $fatal(1);
  end

  task automatic report_mismatch(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    $display("Simulation finished: FAIL");
  endtask

  task automatic report_stall(input string msg);
    $display("Gave up waiting at %0t: %s", $time, msg);
    $display("Simulation finished: FAIL");
  endtask

  task automatic set_time(input logic [2:0] min, input logic [2:0] sec_ten,
                          input logic [3:0] sec_one);
    game_time.min     = min;
    game_time.sec_ten = sec_ten;
    game_time.sec_one = sec_one;
  endtask

  // one-cycle trigger, raised on the current falling edge
  task automatic fire_event(input cue_e cue);
    case (cue)
      CUE_ERR:  error        = 1'b1;
      CUE_BOOM: game_clear   = 1'b1;
      default:  puzzle_clear = 1'b1;
    endcase
    @(negedge clk);
    error        = 1'b0;
    game_clear   = 1'b0;
    puzzle_clear = 1'b0;
  endtask

  // low cycles before the rise go to last_gap, high cycles to width
  task automatic measure_pulse(input string what, input int max_wait, output int width);
    int low;
    low   = 0;
    width = 0;
    while (!audio) begin
      assert (low < max_wait) else begin
        report_stall($sformatf("no %s pulse within %0d cycles", what, max_wait));
        $fatal(1);
      end
      @(negedge clk);
      low++;
    end
    last_rise = cyc;
    last_gap  = low;
    while (audio) begin
      @(negedge clk);
      width++;
    end
  endtask

  // count pulses of a burst, each half wide with half low in between
  task automatic expect_pulses(input string what, input int count, input int half,
                               input int first_wait);
    int width;
    for (int i = 0; i < count; i++) begin
      measure_pulse(what, (i == 0) ? first_wait : half + 2, width);
      if (i == 0) begin
        burst_rise = last_rise;
      end
      assert (width == half) else begin
        report_mismatch($sformatf("%s pulse %0d is %0d cycles wide, expected %0d",
                                  what, i, width, half));
        $fatal(1);
      end
      assert (i == 0 || last_gap == half) else begin
        report_mismatch($sformatf("%s gap before pulse %0d is %0d cycles, expected %0d",
                                  what, i, last_gap, half));
        $fatal(1);
      end
    end
  endtask

  task automatic expect_quiet(input string what, input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      assert (!audio) else begin
        report_mismatch($sformatf("audio high during quiet time after %s", what));
        $fatal(1);
      end
    end
  endtask

  // tick is 3 pulses, 4 cycles wide
  task automatic expect_tick_burst(input int max_wait);
    expect_pulses("tick", 3, 4, max_wait);
    expect_quiet("tick", QUIET_CYCLES);
  endtask

  task automatic check_tick_period(input int period);
    int first;
    expect_tick_burst(period + 20);
    first = burst_rise;
    expect_tick_burst(period + 20);
    assert (burst_rise - first == period) else begin
      report_mismatch($sformatf("tick bursts %0d cycles apart, expected %0d",
                                burst_rise - first, period));
      $fatal(1);
    end
  endtask

  task automatic test_quiet_after_reset();
    expect_quiet("reset", 390);
  endtask

  task automatic test_tick_pace();
    check_tick_period(400);
    // 0:30, fast band
    set_time(3'd0, 3'd3, 4'd0);
    check_tick_period(200);
    // 0:10, faster band
    set_time(3'd0, 3'd1, 4'd0);
    check_tick_period(100);
    set_time(3'd5, 3'd0, 4'd0);
  endtask

  // trigger right after a tick so the next tick is far off
  task automatic play_event(input cue_e cue, input string what, input int count,
                            input int half);
    expect_tick_burst(420);
    fire_event(cue);
    expect_pulses(what, count, half, half + 6);
    expect_quiet(what, QUIET_CYCLES);
  endtask

  task automatic test_event_tones();
    play_event(CUE_ERR, "error", 10, 6);
    play_event(CUE_BOOM, "boom", 8, 15);
    play_event(CUE_PZL, "puzzle", 6, 9);
  endtask

  task automatic test_preemption();
    expect_tick_burst(420);
    fire_event(CUE_PZL);
    expect_pulses("puzzle", 2, 9, 15);
    // error lands in a low gap of the chirp
    fire_event(CUE_ERR);
    expect_pulses("error over puzzle", 10, 6, 12);
    // puzzle starts over in full
    expect_pulses("resumed puzzle", 6, 9, 18);
    expect_quiet("resumed puzzle", QUIET_CYCLES);
  endtask

  task automatic test_retrigger();
    int first;
    expect_tick_burst(420);
    fire_event(CUE_ERR);
    expect_pulses("error", 3, 6, 12);
    first = burst_rise;
    fire_event(CUE_ERR);
    // the trigger used one low cycle, rest of the gap must follow
    expect_pulses("error after retrigger", 7, 6, 6);
    // pulse 3 keeps the 12 cycle spacing of an unbroken burst
    assert (burst_rise - first == 3 * 12) else begin
      report_mismatch($sformatf("error pulse 3 rose %0d cycles after pulse 0, expected %0d",
                                burst_rise - first, 3 * 12));
      $fatal(1);
    end
    expect_quiet("error after retrigger", QUIET_CYCLES);
  endtask

  initial begin
    nrst         = 1'b0;
    error        = 1'b0;
    puzzle_clear = 1'b0;
    game_clear   = 1'b0;
    set_time(3'd5, 3'd0, 4'd0);
    repeat (3) @(negedge clk);
    nrst = 1'b1;
    test_quiet_after_reset();
    test_tick_pace();
    test_event_tones();
    test_preemption();
    test_retrigger();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- src.f
design/game_clock_pkg.sv
design/audio_cue_pkg.sv
design/tick_pacer.sv
design/event_cue_ctrl.sv
design/tone_synth.sv
design/audio_top.sv
verification/audio_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the audio testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module audio_tb -f src.f \
  -o sim_audio > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_audio > sim.log 2>&1
grep -q "Simulation finished: FAIL" sim.log && { echo "test failed, see sim.log"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "no result in sim.log"; exit 1; }
echo "test passed"
